//--- rtl/cpu_pkg.sv
package cpu_pkg;

    localparam logic [31:0] RESET_PC = 32'h1c00_0000;
    localparam int          ALU_OPS  = 12;

    // one-hot alu operation bit positions
    localparam int ALU_ADD  = 0;
    localparam int ALU_SUB  = 1;
    localparam int ALU_SLT  = 2;
    localparam int ALU_SLTU = 3;
    localparam int ALU_AND  = 4;
    localparam int ALU_NOR  = 5;
    localparam int ALU_OR   = 6;
    localparam int ALU_XOR  = 7;
    localparam int ALU_SLL  = 8;
    localparam int ALU_SRL  = 9;
    localparam int ALU_SRA  = 10;
    localparam int ALU_LUI  = 11;

    typedef logic [ALU_OPS-1:0] alu_op_t;

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
    } fs_to_ds_t;

    typedef struct packed {
        alu_op_t     alu_op;
        logic        src1_is_pc;
        logic [31:0] pc;
        logic [31:0] rj_value;
        logic        src2_is_imm;
        logic [31:0] imm;
        logic [31:0] rkd_value;
        logic        gr_we;
        logic [4:0]  dest;
    } ds_to_es_t;

    typedef struct packed {
        logic [31:0] pc;
        logic        gr_we;
        logic [4:0]  dest;
        logic [31:0] result;
    } es_to_ws_t;

    typedef struct packed {
        logic        taken;
        logic [31:0] target;
    } br_bus_t;

    typedef struct packed {
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } rf_wr_t;

    // pending register write seen by the hazard check
    typedef struct packed {
        logic       valid;
        logic [4:0] dest;
    } dest_info_t;

endpackage

//--- rtl/stage_reg.sv
`timescale 1ns/1ps

module stage_reg #(
    parameter type payload_t = logic [31:0]
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     in_valid,
    input  payload_t in_bus,
    output logic     in_allowin,
    output logic     out_valid,
    output payload_t out_bus,
    input  logic     out_allowin
);

    // empty, or the held payload leaves on this edge
    assign in_allowin = !out_valid || out_allowin;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (flush) begin
            out_valid <= 1'b0;
        end else if (in_allowin) begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_allowin) begin
            out_bus <= in_bus;
        end
    end

endmodule

//--- rtl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        ds_allowin,
    input  br_bus_t     br_bus,
    input  logic [31:0] inst_rdata,
    output logic [31:0] inst_addr,
    output logic        fs_valid,
    output fs_to_ds_t   fs_bus
);

    logic [31:0] pc;
    logic [31:0] seq_pc;
    logic        fs_go;

    // the rom answers in the same cycle, so a request is always out
    assign fs_valid = 1'b1;
    assign fs_go    = fs_valid && ds_allowin;
    assign seq_pc   = pc + 32'd4;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_PC;
        end else if (br_bus.taken) begin
            pc <= br_bus.target;   // redirect wins over sequential
        end else if (fs_go) begin
            pc <= seq_pc;
        end
    end

    assign inst_addr   = pc;
    assign fs_bus.pc   = pc;
    assign fs_bus.inst = inst_rdata;

endmodule

//--- rtl/regfile.sv
`timescale 1ns/1ps

module regfile import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  raddr1,
    input  logic [4:0]  raddr2,
    input  rf_wr_t      wr,
    output logic [31:0] rdata1,
    output logic [31:0] rdata2
);

    logic [31:0] rf [32];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                rf[i] <= '0;
            end
        end else if (wr.we && wr.waddr != 5'd0) begin   // r0 stays zero
            rf[wr.waddr] <= wr.wdata;
        end
    end

    assign rdata1 = rf[raddr1];
    assign rdata2 = rf[raddr2];

endmodule

//--- rtl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import cpu_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       ds_valid,
    input  fs_to_ds_t  ds_bus,
    input  logic       es_allowin,
    input  dest_info_t es_dest,
    input  dest_info_t ws_dest,
    input  rf_wr_t     rf_wr,
    output logic       ds_ready_go,
    output logic       ds_to_es_valid,
    output ds_to_es_t  ds_to_es_bus,
    output br_bus_t    br_bus
);

    logic [31:0] inst;
    logic [5:0]  op_31_26;
    logic [3:0]  op_25_22;
    logic [1:0]  op_21_20;
    logic [4:0]  op_19_15;
    logic [4:0]  rd;
    logic [4:0]  rj;
    logic [4:0]  rk;
    logic [11:0] i12;
    logic [19:0] i20;
    logic [15:0] i16;
    logic [25:0] i26;
    logic        grp_3r;
    logic        grp_shift;
    logic        inst_add_w;
    logic        inst_sub_w;
    logic        inst_slt;
    logic        inst_sltu;
    logic        inst_and;
    logic        inst_or;
    logic        inst_xor;
    logic        inst_nor;
    logic        inst_slli_w;
    logic        inst_srli_w;
    logic        inst_srai_w;
    logic        inst_addi_w;
    logic        inst_lu12i_w;
    logic        inst_jirl;
    logic        inst_b;
    logic        inst_bl;
    logic        inst_beq;
    logic        inst_bne;
    logic        need_ui5;
    logic        need_si20;
    logic        need_si26;
    logic        src2_is_4;
    logic        need_rj;
    logic        need_rkd;
    logic        src_reg_is_rd;
    logic [4:0]  rf_raddr2;
    logic [31:0] rj_value;
    logic [31:0] rkd_value;
    logic [31:0] si16_offs;
    logic [31:0] si26_offs;
    logic        br_cond;

    function automatic logic dest_hit(input logic [4:0] addr, input dest_info_t a,
                                      input dest_info_t b);
        return (addr != 5'd0) && ((a.valid && a.dest == addr) || (b.valid && b.dest == addr));
    endfunction

    assign inst     = ds_bus.inst;
    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    assign rd       = inst[4:0];
    assign rj       = inst[9:5];
    assign rk       = inst[14:10];
    assign i12      = inst[21:10];
    assign i20      = inst[24:5];
    assign i16      = inst[25:10];
    assign i26      = {inst[9:0], inst[25:10]};

    assign grp_3r    = (op_31_26 == 6'h00) && (op_25_22 == 4'h0) && (op_21_20 == 2'h1);
    assign grp_shift = (op_31_26 == 6'h00) && (op_25_22 == 4'h1) && (op_21_20 == 2'h0);

    assign inst_add_w   = grp_3r && (op_19_15 == 5'h00);
    assign inst_sub_w   = grp_3r && (op_19_15 == 5'h02);
    assign inst_slt     = grp_3r && (op_19_15 == 5'h04);
    assign inst_sltu    = grp_3r && (op_19_15 == 5'h05);
    assign inst_nor     = grp_3r && (op_19_15 == 5'h08);
    assign inst_and     = grp_3r && (op_19_15 == 5'h09);
    assign inst_or      = grp_3r && (op_19_15 == 5'h0a);
    assign inst_xor     = grp_3r && (op_19_15 == 5'h0b);
    assign inst_slli_w  = grp_shift && (op_19_15 == 5'h01);
    assign inst_srli_w  = grp_shift && (op_19_15 == 5'h09);
    assign inst_srai_w  = grp_shift && (op_19_15 == 5'h11);
    assign inst_addi_w  = (op_31_26 == 6'h00) && (op_25_22 == 4'ha);
    assign inst_lu12i_w = (op_31_26 == 6'h05) && !inst[25];
    assign inst_jirl    = (op_31_26 == 6'h13);
    assign inst_b       = (op_31_26 == 6'h14);
    assign inst_bl      = (op_31_26 == 6'h15);
    assign inst_beq     = (op_31_26 == 6'h16);
    assign inst_bne     = (op_31_26 == 6'h17);

    assign need_ui5  = inst_slli_w || inst_srli_w || inst_srai_w;
    assign need_si20 = inst_lu12i_w;
    assign need_si26 = inst_b || inst_bl;
    assign src2_is_4 = inst_jirl || inst_bl;   // link value is pc+4

    assign si16_offs = {{14{i16[15]}}, i16, 2'b00};
    assign si26_offs = {{4{i26[25]}}, i26, 2'b00};

    // only registers an instruction really reads may stall it
    assign need_rkd      = inst_add_w || inst_sub_w || inst_slt || inst_sltu || inst_and
                         || inst_or || inst_xor || inst_nor || inst_beq || inst_bne;
    assign need_rj       = need_rkd || need_ui5 || inst_addi_w || inst_jirl;
    assign src_reg_is_rd = inst_beq || inst_bne;
    assign rf_raddr2     = src_reg_is_rd ? rd : rk;

    regfile u_regfile (
        .clk    (clk),
        .rst_n  (rst_n),
        .raddr1 (rj),
        .raddr2 (rf_raddr2),
        .wr     (rf_wr),
        .rdata1 (rj_value),
        .rdata2 (rkd_value)
    );

    assign ds_ready_go = !((need_rj && dest_hit(rj, es_dest, ws_dest))
                         || (need_rkd && dest_hit(rf_raddr2, es_dest, ws_dest)));
    assign ds_to_es_valid = ds_valid && ds_ready_go;

    assign ds_to_es_bus.alu_op = {inst_lu12i_w, inst_srai_w, inst_srli_w, inst_slli_w,
                                  inst_xor, inst_or, inst_nor, inst_and, inst_sltu, inst_slt,
                                  inst_sub_w, inst_add_w || inst_addi_w || src2_is_4};
    assign ds_to_es_bus.src1_is_pc  = src2_is_4;
    assign ds_to_es_bus.pc          = ds_bus.pc;
    assign ds_to_es_bus.rj_value    = rj_value;
    assign ds_to_es_bus.src2_is_imm = need_ui5 || inst_addi_w || need_si20 || src2_is_4;
    assign ds_to_es_bus.imm         = src2_is_4 ? 32'd4 :
                                      need_si20 ? {i20, 12'b0} :
                                      need_ui5  ? {27'b0, rk} :
                                                  {{20{i12[11]}}, i12};
    assign ds_to_es_bus.rkd_value   = rkd_value;
    assign ds_to_es_bus.gr_we       = need_rkd && !src_reg_is_rd || need_ui5 || inst_addi_w
                                    || need_si20 || src2_is_4;
    assign ds_to_es_bus.dest        = inst_bl ? 5'd1 : rd;

    assign br_cond = (inst_beq && rj_value == rkd_value) || (inst_bne && rj_value != rkd_value)
                   || inst_jirl || inst_b || inst_bl;

    // redirect only when the branch actually moves on to execute
    assign br_bus.taken  = ds_valid && ds_ready_go && es_allowin && br_cond;
    assign br_bus.target = inst_jirl ? rj_value + si16_offs :
                                       ds_bus.pc + (need_si26 ? si26_offs : si16_offs);

endmodule

//--- rtl/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import cpu_pkg::*; (
    input  logic      es_valid,
    input  ds_to_es_t es_bus,
    input  logic      ws_allowin,
    output logic      es_allowin,
    output logic      es_to_ws_valid,
    output es_to_ws_t es_to_ws_bus
);

    logic [31:0] src1;
    logic [31:0] src2;
    logic [31:0] add_sub_res;
    logic        slt_res;
    logic        sltu_res;
    logic [31:0] sll_res;
    logic [31:0] srl_res;
    logic [31:0] sra_res;
    logic [4:0]  shamt;
    alu_op_t     op;

    assign op   = es_bus.alu_op;
    assign src1 = es_bus.src1_is_pc ? es_bus.pc : es_bus.rj_value;
    assign src2 = es_bus.src2_is_imm ? es_bus.imm : es_bus.rkd_value;

    assign add_sub_res = op[ALU_SUB] ? src1 - src2 : src1 + src2;
    assign slt_res     = $signed(src1) < $signed(src2);
    assign sltu_res    = src1 < src2;

    assign shamt   = src2[4:0];
    assign sll_res = src1 << shamt;
    assign srl_res = src1 >> shamt;
    assign sra_res = $unsigned($signed(src1) >>> shamt);

    // alu_op is one-hot, so an and-or mux picks the result
    assign es_to_ws_bus.result = ({32{op[ALU_ADD] | op[ALU_SUB]}} & add_sub_res)
                               | ({32{op[ALU_SLT]}}  & {31'b0, slt_res})
                               | ({32{op[ALU_SLTU]}} & {31'b0, sltu_res})
                               | ({32{op[ALU_AND]}}  & (src1 & src2))
                               | ({32{op[ALU_NOR]}}  & ~(src1 | src2))
                               | ({32{op[ALU_OR]}}   & (src1 | src2))
                               | ({32{op[ALU_XOR]}}  & (src1 ^ src2))
                               | ({32{op[ALU_SLL]}}  & sll_res)
                               | ({32{op[ALU_SRL]}}  & srl_res)
                               | ({32{op[ALU_SRA]}}  & sra_res)
                               | ({32{op[ALU_LUI]}}  & src2);   // imm already shifted

    assign es_to_ws_bus.pc    = es_bus.pc;
    assign es_to_ws_bus.gr_we = es_bus.gr_we;
    assign es_to_ws_bus.dest  = es_bus.dest;

    // single-cycle alu, always ready
    assign es_allowin     = !es_valid || ws_allowin;
    assign es_to_ws_valid = es_valid;

endmodule

//--- rtl/cpu_core.sv
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [31:0] inst_rdata,
    output logic [31:0] inst_addr,
    output logic        trace_valid,
    output logic [31:0] trace_pc,
    output logic        trace_we,
    output logic [4:0]  trace_waddr,
    output logic [31:0] trace_wdata
);

    logic       fs_valid;
    fs_to_ds_t  fs_bus;
    logic       ds_allowin;
    logic       ds_valid;
    fs_to_ds_t  ds_bus;
    logic       ds_ready_go;
    logic       fd_out_allowin;
    logic       ds_to_es_valid;
    ds_to_es_t  ds_to_es_bus;
    logic       de_in_allowin;
    logic       es_valid;
    ds_to_es_t  es_bus;
    logic       es_allowin;
    logic       es_to_ws_valid;
    es_to_ws_t  es_to_ws_bus;
    logic       ws_allowin;
    logic       ws_valid;
    es_to_ws_t  ws_bus;
    br_bus_t    br_bus;
    rf_wr_t     rf_wr;
    dest_info_t es_dest;
    dest_info_t ws_dest;

    fetch_stage u_fetch (
        .clk(clk), .rst_n(rst_n), .ds_allowin(ds_allowin), .br_bus(br_bus),
        .inst_rdata(inst_rdata), .inst_addr(inst_addr), .fs_valid(fs_valid), .fs_bus(fs_bus)
    );

    // taken branch drops the instruction fetched behind it
    stage_reg #(.payload_t(fs_to_ds_t)) u_fd_reg (
        .clk(clk), .rst_n(rst_n), .flush(br_bus.taken), .in_valid(fs_valid), .in_bus(fs_bus),
        .in_allowin(ds_allowin), .out_valid(ds_valid), .out_bus(ds_bus),
        .out_allowin(fd_out_allowin)
    );

    assign fd_out_allowin = ds_ready_go && de_in_allowin;

    decode_stage u_decode (
        .clk(clk), .rst_n(rst_n), .ds_valid(ds_valid), .ds_bus(ds_bus),
        .es_allowin(de_in_allowin), .es_dest(es_dest), .ws_dest(ws_dest), .rf_wr(rf_wr),
        .ds_ready_go(ds_ready_go), .ds_to_es_valid(ds_to_es_valid),
        .ds_to_es_bus(ds_to_es_bus), .br_bus(br_bus)
    );

    stage_reg #(.payload_t(ds_to_es_t)) u_de_reg (
        .clk(clk), .rst_n(rst_n), .flush(1'b0), .in_valid(ds_to_es_valid),
        .in_bus(ds_to_es_bus), .in_allowin(de_in_allowin), .out_valid(es_valid),
        .out_bus(es_bus), .out_allowin(es_allowin)
    );

    exec_stage u_exec (
        .es_valid(es_valid), .es_bus(es_bus), .ws_allowin(ws_allowin),
        .es_allowin(es_allowin), .es_to_ws_valid(es_to_ws_valid), .es_to_ws_bus(es_to_ws_bus)
    );

    stage_reg #(.payload_t(es_to_ws_t)) u_ew_reg (
        .clk(clk), .rst_n(rst_n), .flush(1'b0), .in_valid(es_to_ws_valid),
        .in_bus(es_to_ws_bus), .in_allowin(ws_allowin), .out_valid(ws_valid),
        .out_bus(ws_bus), .out_allowin(1'b1)   // writeback retires every cycle
    );

    assign es_dest = '{valid: es_valid && es_bus.gr_we, dest: es_bus.dest};
    assign ws_dest = '{valid: ws_valid && ws_bus.gr_we, dest: ws_bus.dest};

    assign rf_wr = '{we: ws_valid && ws_bus.gr_we, waddr: ws_bus.dest, wdata: ws_bus.result};

    assign trace_valid = ws_valid;
    assign trace_pc    = ws_bus.pc;
    assign trace_we    = ws_bus.gr_we;
    assign trace_waddr = ws_bus.dest;
    assign trace_wdata = ws_bus.result;

endmodule

//--- tb/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
    parameter int PERIOD_NS    = 8,
    parameter int RESET_CYCLES = 4
) (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);   // release away from the rising edge
        rst_n = 1'b1;
    end

endmodule

//--- tb/tb_top.sv
`timescale 1ns/1ps

module tb_top import cpu_pkg::*; ();

    localparam int          PROG_LEN   = 29;
    localparam int          MAX_CYCLES = 8 * PROG_LEN + 50;
    localparam logic [31:0] ROM_BYTES  = PROG_LEN * 4;

    // one expected entry on the commit trace
    typedef struct packed {
        logic [31:0] pc;
        logic        we;
        logic [4:0]  waddr;
        logic [31:0] wdata;
    } commit_t;

    logic        clk;
    logic        rst_n;
    logic [31:0] inst_addr;
    logic [31:0] inst_rdata;
    logic        trace_valid;
    logic [31:0] trace_pc;
    logic        trace_we;
    logic [4:0]  trace_waddr;
    logic [31:0] trace_wdata;
    logic [31:0] rom_off;
    logic [31:0] prog [32];
    commit_t     exp_q [$];
    string       name_q [$];
    int          idx;
    int          cycles;
    int          pass_cnt;
    int          fail_cnt;
    int          group_base;

    tb_clkgen #(.PERIOD_NS(8), .RESET_CYCLES(4)) u_clkgen (.clk(clk), .rst_n(rst_n));

    cpu_core UUT (
        .clk(clk), .rst_n(rst_n), .inst_rdata(inst_rdata), .inst_addr(inst_addr),
        .trace_valid(trace_valid), .trace_pc(trace_pc), .trace_we(trace_we),
        .trace_waddr(trace_waddr), .trace_wdata(trace_wdata)
    );

    // instruction rom, word index counted from RESET_PC
    assign rom_off    = inst_addr - RESET_PC;
    assign inst_rdata = (rom_off < ROM_BYTES) ? prog[rom_off[6:2]] : 32'h0;

    task automatic add_row(input string name, input int slot, input logic [31:0] word,
                           input logic we, input logic [4:0] waddr, input logic [31:0] wdata);
        commit_t c;
        prog[slot] = word;
        c.pc       = RESET_PC + 32'(slot * 4);
        c.we       = we;
        c.waddr    = waddr;
        c.wdata    = wdata;
        exp_q.push_back(c);
        name_q.push_back(name);
    endtask

    // rows in commit order, so the branch targets appear where they retire
    task automatic build_program();
        add_row("reset",       0, 32'h1500_0001, 1'b1, 5'd1,  32'h8000_0000); // lu12i.w r1
        add_row("alu",         1, 32'h02bf_ec02, 1'b1, 5'd2,  32'hffff_fffb); // addi.w r2,-5
        add_row("alu",         2, 32'h0280_1c03, 1'b1, 5'd3,  32'h0000_0007); // addi.w r3,7
        add_row("alu",         3, 32'h0010_0c44, 1'b1, 5'd4,  32'h0000_0002); // add.w
        add_row("alu",         4, 32'h0011_0c45, 1'b1, 5'd5,  32'hffff_fff4); // sub.w
        add_row("alu",         5, 32'h0012_0c46, 1'b1, 5'd6,  32'h0000_0001); // slt
        add_row("alu",         6, 32'h0012_8c47, 1'b1, 5'd7,  32'h0000_0000); // sltu
        add_row("alu",         7, 32'h0014_8c48, 1'b1, 5'd8,  32'h0000_0003); // and
        add_row("alu",         8, 32'h0015_0c49, 1'b1, 5'd9,  32'hffff_ffff); // or
        add_row("alu",         9, 32'h0015_8c4a, 1'b1, 5'd10, 32'hffff_fffc); // xor
        add_row("alu",        10, 32'h0014_0c4b, 1'b1, 5'd11, 32'h0000_0000); // nor
        add_row("alu",        11, 32'h0040_906c, 1'b1, 5'd12, 32'h0000_0070); // slli.w r3,4
        add_row("alu",        12, 32'h0044_902d, 1'b1, 5'd13, 32'h0800_0000); // srli.w r1,4
        add_row("alu",        13, 32'h0048_902e, 1'b1, 5'd14, 32'hf800_0000); // srai.w r1,4
        add_row("dependency", 14, 32'h0280_046f, 1'b1, 5'd15, 32'h0000_0008); // addi.w r15,r3,1
        add_row("dependency", 15, 32'h0010_3df0, 1'b1, 5'd16, 32'h0000_0010); // add r15,r15
        add_row("dependency", 16, 32'h0011_3e11, 1'b1, 5'd17, 32'h0000_0008); // sub r16,r15
        add_row("branch",     17, 32'h5800_09f1, 1'b0, 5'd0,  32'h0);         // beq taken +8
        prog[18] = 32'h0284_4412;                                // addi.w r18 jumped over by beq
        add_row("branch",     19, 32'h5c00_09f1, 1'b0, 5'd0,  32'h0);         // bne not taken
        add_row("branch",     20, 32'h0280_8812, 1'b1, 5'd18, 32'h0000_0022);
        add_row("branch",     21, 32'h5400_0c00, 1'b1, 5'd1,  32'h1c00_0058); // bl +12
        add_row("branch",     24, 32'h0281_1014, 1'b1, 5'd20, 32'h0000_0044);
        add_row("branch",     25, 32'h4c00_0020, 1'b1, 5'd0,  32'h1c00_0068); // jirl r0,r1,0
        add_row("branch",     22, 32'h0280_cc13, 1'b1, 5'd19, 32'h0000_0033);
        add_row("branch",     23, 32'h5000_0c00, 1'b0, 5'd0,  32'h0);         // b +12
        add_row("r0",         26, 32'h0281_5400, 1'b1, 5'd0,  32'h0000_0055); // addi.w r0
        add_row("r0",         27, 32'h0010_0c15, 1'b1, 5'd21, 32'h0000_0007); // add r21,r0,r3
        add_row("r0",         28, 32'h5000_0000, 1'b0, 5'd0,  32'h0);         // b 0
    endtask

    task automatic check_equal(input string test, input string field,
                               input logic [31:0] expected, input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Mismatch %s %s: expected %h, actual %h", test, field, expected, actual);
            fail_cnt++;
        end else begin
            pass_cnt++;
        end
    endtask

    function automatic bit pc_in_program(input logic [31:0] pc);
        foreach (exp_q[i]) begin
            if (exp_q[i].pc == pc) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic sample_trace();
        commit_t cur;
        if (!rst_n) begin
            check_equal("reset", "inst_addr", RESET_PC, inst_addr);
            if (trace_valid !== 1'b0) begin
                $display("Commit trace is valid while reset is still asserted");
                fail_cnt++;
            end
        end else if (trace_valid) begin
            if (!pc_in_program(trace_pc)) begin
                $display("Instruction at pc %h retired although it must never commit", trace_pc);
                fail_cnt++;
            end else begin
                cur = exp_q[idx];
                check_equal(name_q[idx], "pc", cur.pc, trace_pc);
                check_equal(name_q[idx], "we", {31'b0, cur.we}, {31'b0, trace_we});
                if (cur.we) begin   // address and data only mean something on a write
                    check_equal(name_q[idx], "waddr", {27'b0, cur.waddr}, {27'b0, trace_waddr});
                    check_equal(name_q[idx], "wdata", cur.wdata, trace_wdata);
                end
                if (idx + 1 == exp_q.size() || name_q[idx + 1] != name_q[idx]) begin
                    $display("test %s finished, %0d errors", name_q[idx], fail_cnt - group_base);
                    group_base = fail_cnt;
                end
                idx++;
            end
        end
    endtask

    initial begin
        idx        = 0;
        cycles     = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        group_base = 0;
        build_program();
        while (idx < exp_q.size() && cycles < MAX_CYCLES) begin
            @(negedge clk);
            cycles++;
            sample_trace();
        end
        if (idx < exp_q.size()) begin
            $display("Timeout after %0d cycles, only %0d of %0d commits were seen",
                     cycles, idx, exp_q.size());
            fail_cnt++;
        end
        $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- tb.f
rtl/cpu_pkg.sv
rtl/stage_reg.sv
rtl/fetch_stage.sv
rtl/regfile.sv
rtl/decode_stage.sv
rtl/exec_stage.sv
rtl/cpu_core.sv
tb/tb_clkgen.sv
tb/tb_top.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := tb_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
